/* Makefile */
# Verilator simulation of the line aggregator

VERILATOR ?= verilator
TOP       ?= tb_pipe_aggregator
FILELIST  ?= pipe_aggregator.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_BIN   ?= V$(TOP)
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the log decides the result, the simulator exit code is not used
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(SIM_BIN) -f $(FILELIST)
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/aggre_out_stage.sv */
`default_nettype none

module aggre_out_stage (
   input  logic                   aggre_clk,
   input  logic                   aggre_clk_rst_n,
   input  aggre_pkg::bus_word_t   bus_in [aggre_pkg::NUM_PIPES],
   output aggre_pkg::agg_out_t    agg_out
);

   aggre_pkg::bus_word_t   bus_or;
   aggre_pkg::pipe_id_t    bus_id;
   aggre_pkg::pipe_mask_t  drive_mask;
   logic                   out_valid;
   aggre_pkg::pipe_id_t    out_id;
   aggre_pkg::pix_t        out_data;
   logic                   out_last;

   // idle pipes drive zeros, so a plain OR merges the bus
   always_comb begin
      bus_or = '0;
      bus_id = '0;
      for (int i = 0; i < aggre_pkg::NUM_PIPES; i++) begin
         bus_or        = bus_or | bus_in[i];
         drive_mask[i] = bus_in[i].valid;
         if (bus_in[i].valid) begin
            bus_id = aggre_pkg::pipe_id_t'(i);
         end
      end
   end

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= bus_or.valid;
      end
   end

   always_ff @(posedge aggre_clk) begin
      out_id   <= bus_id;
      out_data <= bus_or.data;
      out_last <= bus_or.last;
   end

   assign agg_out.valid   = out_valid;
   assign agg_out.pipe_id = out_id;
   assign agg_out.data    = out_data;
   assign agg_out.last    = out_valid && out_last;

   a_single_driver: assert property (
      @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
      $onehot0(drive_mask)
   ) else $error("aggre_out_stage: several pipes drive the bus");

endmodule

`default_nettype wire

/* hw/aggre_pkg.sv */
`default_nettype none

package aggre_pkg;

   localparam int NUM_PIPES   = 8;
   localparam int PIX_W       = 16;
   localparam int STORE_DEPTH = 32;
   localparam int LINE_CNT_W  = 3;
   localparam int STORE_PTR_W = $clog2(STORE_DEPTH);

   typedef logic [2:0]              pipe_id_t;
   typedef logic [PIX_W-1:0]        pix_t;
   typedef logic [NUM_PIPES-1:0]    pipe_mask_t;
   typedef logic [1:0]              aggre_mode_t;
   typedef logic [LINE_CNT_W-1:0]   line_cnt_t;
   typedef logic [STORE_PTR_W-1:0]  store_ptr_t;
   typedef logic [STORE_PTR_W:0]    store_cnt_t;

   // aggregation method 2
   localparam aggre_mode_t AGGRE_M2 = 2'd3;

   typedef enum logic [2:0] {
      SCH_IDLE,
      SCH_ORDER,
      SCH_WAIT_ACK,
      SCH_CLEAR_STATE,
      SCH_WAIT_LINE_END
   } sch_state_t;

   typedef struct packed {
      logic     valid;
      pix_t     data;
      logic     last;
   } pix_in_t;

   typedef struct packed {
      logic     valid;
      pix_t     data;
      logic     last;
   } bus_word_t;

   // pipe reply to the scheduler
   typedef struct packed {
      logic     ready;
      logic     ack;
      logic     line_end;
   } pipe_status_t;

   typedef struct packed {
      logic     valid;
      pipe_id_t pipe_id;
      pix_t     data;
      logic     last;
   } agg_out_t;

endpackage

`default_nettype wire

/* hw/pipe_aggregator.sv */
`default_nettype none

module pipe_aggregator (
   input  logic                     aggre_clk,
   input  logic                     aggre_clk_rst_n,
   input  aggre_pkg::aggre_mode_t   aggre_mode,
   input  aggre_pkg::pipe_mask_t    pipe_enable,
   input  aggre_pkg::pix_in_t       pix_in [aggre_pkg::NUM_PIPES],
   output aggre_pkg::agg_out_t      agg_out
);

   aggre_pkg::pipe_status_t  pipe_status [aggre_pkg::NUM_PIPES];
   aggre_pkg::bus_word_t     pipe_bus    [aggre_pkg::NUM_PIPES];
   aggre_pkg::pipe_mask_t    grant;

   // eight peer pipes on one shared bus
   for (genvar i = 0; i < aggre_pkg::NUM_PIPES; i++) begin : g_pipe
      video_pipe u_video_pipe (
         .aggre_clk       (aggre_clk),
         .aggre_clk_rst_n (aggre_clk_rst_n),
         .enable          (pipe_enable[i]),
         .pix_in          (pix_in[i]),
         .grant           (grant[i]),
         .status          (pipe_status[i]),
         .bus_out         (pipe_bus[i])
      );
   end

   pipe_line_scheduler u_scheduler (
      .aggre_clk       (aggre_clk),
      .aggre_clk_rst_n (aggre_clk_rst_n),
      .aggre_mode      (aggre_mode),
      .status          (pipe_status),
      .grant           (grant)
   );

   aggre_out_stage u_out_stage (
      .aggre_clk       (aggre_clk),
      .aggre_clk_rst_n (aggre_clk_rst_n),
      .bus_in          (pipe_bus),
      .agg_out         (agg_out)
   );

endmodule

`default_nettype wire

/* hw/pipe_line_scheduler.sv */
`default_nettype none

module pipe_line_scheduler (
   input  logic                     aggre_clk,
   input  logic                     aggre_clk_rst_n,
   input  aggre_pkg::aggre_mode_t   aggre_mode,
   input  aggre_pkg::pipe_status_t  status [aggre_pkg::NUM_PIPES],
   output aggre_pkg::pipe_mask_t    grant
);

   aggre_pkg::sch_state_t  state;
   aggre_pkg::sch_state_t  state_ns;
   aggre_pkg::pipe_mask_t  ready_mask;
   aggre_pkg::pipe_mask_t  pick_mask;
   aggre_pkg::pipe_mask_t  ack_mask;
   aggre_pkg::pipe_mask_t  line_end_mask;

   always_comb begin
      for (int i = 0; i < aggre_pkg::NUM_PIPES; i++) begin
         ready_mask[i]    = status[i].ready && (aggre_mode == aggre_pkg::AGGRE_M2);
         ack_mask[i]      = status[i].ack;
         line_end_mask[i] = status[i].line_end;
      end
   end

   // lowest index wins
   assign pick_mask = ready_mask & (~ready_mask + 1'b1);

   always_comb begin
      state_ns = state;
      case (state)
         aggre_pkg::SCH_IDLE: begin
            if (|pick_mask) begin
               state_ns = aggre_pkg::SCH_ORDER;
            end
         end
         aggre_pkg::SCH_ORDER: begin
            state_ns = aggre_pkg::SCH_WAIT_ACK;
         end
         aggre_pkg::SCH_WAIT_ACK: begin
            if (|ack_mask) begin
               state_ns = aggre_pkg::SCH_CLEAR_STATE;
            end
         end
         aggre_pkg::SCH_CLEAR_STATE: begin
            // a one-word line already ends here
            if (|line_end_mask) begin
               state_ns = aggre_pkg::SCH_IDLE;
            end else begin
               state_ns = aggre_pkg::SCH_WAIT_LINE_END;
            end
         end
         aggre_pkg::SCH_WAIT_LINE_END: begin
            if (|line_end_mask) begin
               state_ns = aggre_pkg::SCH_IDLE;
            end
         end
         default: begin
            state_ns = aggre_pkg::SCH_IDLE;
         end
      endcase
   end

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         state <= aggre_pkg::SCH_IDLE;
         grant <= '0;
      end else begin
         state <= state_ns;
         if ((state == aggre_pkg::SCH_IDLE) && (state_ns == aggre_pkg::SCH_ORDER)) begin
            grant <= pick_mask;
         end else if (state_ns == aggre_pkg::SCH_CLEAR_STATE) begin
            grant <= grant & ~ack_mask;
         end
      end
   end

   a_grant_onehot: assert property (
      @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
      $onehot0(grant)
   ) else $error("pipe_line_scheduler: more than one grant");

   a_ack_from_granted: assert property (
      @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
      (|ack_mask) |-> ((ack_mask & ~grant) == '0)
   ) else $error("pipe_line_scheduler: ack from a pipe without grant");

endmodule

`default_nettype wire

/* hw/video_pipe.sv */
`default_nettype none

module video_pipe (
   input  logic                     aggre_clk,
   input  logic                     aggre_clk_rst_n,
   input  logic                     enable,
   input  aggre_pkg::pix_in_t       pix_in,
   input  logic                     grant,
   output aggre_pkg::pipe_status_t  status,
   output aggre_pkg::bus_word_t     bus_out
);

   // line store holds one data word and its end-of-line flag per entry
   aggre_pkg::pix_t        store_data [aggre_pkg::STORE_DEPTH];
   logic                   store_last [aggre_pkg::STORE_DEPTH];

   aggre_pkg::store_ptr_t  wr_ptr;
   aggre_pkg::store_ptr_t  rd_ptr;
   aggre_pkg::store_cnt_t  word_cnt;
   aggre_pkg::line_cnt_t   line_cnt;
   logic                   full;
   logic                   wr_en;
   logic                   rd_en;
   logic                   rd_last;
   logic                   grant_d;
   logic                   ack;
   logic                   sending;

   assign full    = (word_cnt == aggre_pkg::store_cnt_t'(aggre_pkg::STORE_DEPTH));
   assign wr_en   = pix_in.valid && !full;
   assign rd_en   = sending;
   assign rd_last = store_last[rd_ptr];

   always_ff @(posedge aggre_clk) begin
      if (wr_en) begin
         store_data[wr_ptr] <= pix_in.data;
         store_last[wr_ptr] <= pix_in.last;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         word_cnt <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   word_cnt <= word_cnt + 1'b1;
            2'b01:   word_cnt <= word_cnt - 1'b1;
            default: word_cnt <= word_cnt;
         endcase
      end
   end

   // complete lines held in the store
   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         line_cnt <= '0;
      end else begin
         case ({wr_en && pix_in.last, rd_en && rd_last})
            2'b10:   line_cnt <= line_cnt + 1'b1;
            2'b01:   line_cnt <= line_cnt - 1'b1;
            default: line_cnt <= line_cnt;
         endcase
      end
   end

   // ack one cycle after a new grant and stream from the cycle after ack
   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         grant_d <= 1'b0;
         ack     <= 1'b0;
         sending <= 1'b0;
      end else begin
         grant_d <= grant;
         ack     <= grant && !grant_d;
         if (rd_en && rd_last) begin
            sending <= 1'b0;
         end else if (ack) begin
            sending <= 1'b1;
         end
      end
   end

   assign status.ready    = enable && (line_cnt != '0);
   assign status.ack      = ack;
   assign status.line_end = rd_en && rd_last;

   // idle pipes drive zeros so the bus can be ORed
   assign bus_out.valid = sending;
   assign bus_out.data  = sending ? store_data[rd_ptr] : '0;
   assign bus_out.last  = sending && rd_last;

   a_no_write_when_full: assert property (
      @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
      pix_in.valid |-> !full
   ) else $error("video_pipe: input word dropped, line store full");

   a_grant_needs_line: assert property (
      @(posedge aggre_clk) disable iff (!aggre_clk_rst_n)
      grant |-> (line_cnt != '0)
   ) else $error("video_pipe: granted without a complete line");

endmodule

`default_nettype wire

/* pipe_aggregator.f */
hw/aggre_pkg.sv
hw/video_pipe.sv
hw/pipe_line_scheduler.sv
hw/aggre_out_stage.sv
hw/pipe_aggregator.sv
tests/tb_clk_gen.sv
tests/tb_pipe_aggregator.sv

/* tests/pipe_aggregator_golden.txt */
// record word: kind, test, pipe, last, then 16 bits of data, eight hex digits
// kind 1 input word, 2 expected output word, 3 mode, 4 pipe_enable,
// kind 5 no output over data cycles, f end of list
// test 1: mode 0 holds back lines loaded into pipes 2, 0 and 4
410000FF 31000000
11201201 11211202
11001001 11001002 11011003
11401401 11411402
51000028
// test 2: mode 3 drains them lowest pipe first
32000003
22001001 22001002 22011003
22201201 22211202
22401401 22411402
// test 3: a one-word line in pipe 7, then a four-word line in pipe 3
13713701
13303301 13303302 13303303 13313304
23713701
23303301 23303302 23303303 23313304
// test 4: pipes 1 and 3 stay out until pipe_enable is restored
440000F5
14101401 14111402
14303401 14313402
14606401 14616402
24606401 24616402
5400001E
440000FF
24101401 24111402
24303401 24313402
// test 5: pipe 1 fills while pipe 5 streams and goes ahead of pipe 6
15505501 15505502 15505503 15505504 15505505 15505506 15505507 15515508
15606501 15616502
25505501
15101501 15111502
25505502 25505503 25505504 25505505 25505506 25505507 25515508
25101501 25111502
25606501 25616502
// test 6: two lines in pipe 2 leave in arrival order, each on its own grant
36000000
16202601 16202602 16212603
16202611 16212612
16406441 16416442
56000014
36000003
26202601 26202602 26212603
26202611 26212612
26406441 26416442
F0000000

/* tests/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
   output logic aggre_clk,
   output logic aggre_clk_rst_n
);

   localparam int HALF_PERIOD  = 5;
   localparam int RESET_CYCLES = 10;

   initial begin
      aggre_clk = 1'b0;
      forever #HALF_PERIOD aggre_clk = ~aggre_clk;
   end

   // release away from the rising edge
   initial begin
      aggre_clk_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge aggre_clk);
      @(negedge aggre_clk);
      aggre_clk_rst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* tests/tb_pipe_aggregator.sv */
`default_nettype none

module tb_pipe_aggregator;

   localparam int MAX_RECORDS = 256;
   localparam int WAIT_LIMIT  = 200;
   localparam int DRAIN_WAIT  = 40;

   // record kinds in the golden file
   localparam logic [3:0] REC_INPUT  = 4'h1;
   localparam logic [3:0] REC_EXPECT = 4'h2;
   localparam logic [3:0] REC_MODE   = 4'h3;
   localparam logic [3:0] REC_ENABLE = 4'h4;
   localparam logic [3:0] REC_IDLE   = 4'h5;
   localparam logic [3:0] REC_END    = 4'hf;

   logic                    aggre_clk;
   logic                    aggre_clk_rst_n;
   aggre_pkg::aggre_mode_t  aggre_mode;
   aggre_pkg::pipe_mask_t   pipe_enable;
   aggre_pkg::pix_in_t      pix_in [aggre_pkg::NUM_PIPES];
   aggre_pkg::agg_out_t     agg_out;

   logic [31:0]             records [MAX_RECORDS];
   aggre_pkg::agg_out_t     got_q [$];
   int                      word_errors;
   int                      idle_errors;
   int                      other_errors;
   int                      checked_words;

   tb_clk_gen u_clk_gen (
      .aggre_clk       (aggre_clk),
      .aggre_clk_rst_n (aggre_clk_rst_n)
   );

   pipe_aggregator DUT (
      .aggre_clk       (aggre_clk),
      .aggre_clk_rst_n (aggre_clk_rst_n),
      .aggre_mode      (aggre_mode),
      .pipe_enable     (pipe_enable),
      .pix_in          (pix_in),
      .agg_out         (agg_out)
   );

   // agg_out only changes on the rising edge
   always @(negedge aggre_clk) begin
      if (aggre_clk_rst_n && agg_out.valid) begin
         got_q.push_back(agg_out);
      end
   end

   task automatic clear_inputs();
      for (int i = 0; i < aggre_pkg::NUM_PIPES; i++) begin
         pix_in[i] = '0;
      end
   endtask

   task automatic drive_word(input aggre_pkg::pipe_id_t pipe, input aggre_pkg::pix_t data,
                             input logic last);
      @(negedge aggre_clk);
      clear_inputs();
      pix_in[pipe].valid = 1'b1;
      pix_in[pipe].data  = data;
      pix_in[pipe].last  = last;
   endtask

   task automatic release_inputs();
      @(negedge aggre_clk);
      clear_inputs();
   endtask

   task automatic wait_for_reset_release();
      int waited;
      waited = 0;
      while ((aggre_clk_rst_n !== 1'b1) && waited < WAIT_LIMIT) begin
         @(posedge aggre_clk);
         waited++;
      end
      if (aggre_clk_rst_n !== 1'b1) begin
         other_errors++;
         $display("timeout: reset was never released");
      end
   endtask

   task automatic wait_for_word(output aggre_pkg::agg_out_t word, output logic found);
      int waited;
      waited = 0;
      while (got_q.size() == 0 && waited < WAIT_LIMIT) begin
         @(posedge aggre_clk);
         waited++;
      end
      found = (got_q.size() != 0);
      word  = '0;
      if (found) begin
         word = got_q.pop_front();
      end
   endtask

   task automatic check_word(input string test_name, input aggre_pkg::agg_out_t expected,
                             input aggre_pkg::agg_out_t actual);
      checked_words++;
      if (actual !== expected) begin
         word_errors++;
         $display("FAILED %s: expected pipe %0d data %h last %0b, actual pipe %0d data %h last %0b",
                  test_name, expected.pipe_id, expected.data, expected.last,
                  actual.pipe_id, actual.data, actual.last);
      end
   endtask

   task automatic check_mode_idle(input string test_name, input aggre_pkg::aggre_mode_t mode,
                                  input int words_seen);
      if (words_seen != 0) begin
         idle_errors++;
         $display("FAILED %s: mode %0d expected 0 output words, actual %0d words",
                  test_name, mode, words_seen);
      end
   endtask

   initial begin
      logic [31:0]          rec;
      aggre_pkg::agg_out_t  expected;
      aggre_pkg::agg_out_t  actual;
      logic                 found;
      logic                 done;
      string                test_name;
      int                   idx;
      int                   idle_cycles;

      aggre_mode    = '0;
      pipe_enable   = '0;
      clear_inputs();
      word_errors   = 0;
      idle_errors   = 0;
      other_errors  = 0;
      checked_words = 0;
      $readmemh("tests/pipe_aggregator_golden.txt", records);
      wait_for_reset_release();

      idx  = 0;
      done = 1'b0;
      while (!done && idx < MAX_RECORDS) begin
         rec       = records[idx];
         test_name = $sformatf("test %0d", rec[27:24]);
         if (rec[31:28] != REC_INPUT) begin
            release_inputs();
         end
         case (rec[31:28])
            REC_INPUT: begin
               drive_word(rec[22:20], rec[15:0], rec[16]);
            end
            REC_EXPECT: begin
               expected.valid   = 1'b1;
               expected.pipe_id = rec[22:20];
               expected.data    = rec[15:0];
               expected.last    = rec[16];
               wait_for_word(actual, found);
               if (found) begin
                  check_word(test_name, expected, actual);
               end else begin
                  other_errors++;
                  $display("timeout in %s: no output word arrived for data %h",
                           test_name, expected.data);
               end
            end
            REC_MODE: begin
               aggre_mode = rec[1:0];
            end
            REC_ENABLE: begin
               pipe_enable = rec[7:0];
            end
            REC_IDLE: begin
               idle_cycles = int'(rec[15:0]);
               for (int c = 0; c < idle_cycles; c++) begin
                  @(posedge aggre_clk);
               end
               check_mode_idle(test_name, aggre_mode, got_q.size());
               got_q.delete();
            end
            REC_END: begin
               done = 1'b1;
            end
            default: begin
               other_errors++;
               $display("golden file entry %0d has an unknown record kind", idx);
               done = 1'b1;
            end
         endcase
         idx++;
      end
      if (!done) begin
         other_errors++;
         $display("golden file has no end record");
      end

      // anything still arriving was never expected
      for (int c = 0; c < DRAIN_WAIT; c++) begin
         @(posedge aggre_clk);
      end
      if (got_q.size() != 0) begin
         other_errors++;
         $display("%0d output words arrived that the golden file does not list", got_q.size());
      end

      $display("words checked %0d, word errors %0d, idle errors %0d, other errors %0d",
               checked_words, word_errors, idle_errors, other_errors);
      if (word_errors + idle_errors + other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire
